// ==== logic/ppu_pkg.sv ====
package ppu_pkg;

  // Address and data widths
  typedef logic [12:0] vram_addr_t;
  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0] byte_t;

  // Background color number, high plane bit over low plane bit
  typedef logic [1:0] gb_color_t;

  // STAT style mode encoding
  typedef enum logic [1:0] {
    MODE_HBLANK = 2'd0,
    MODE_VBLANK = 2'd1,
    MODE_OAM    = 2'd2,
    MODE_DRAW   = 2'd3
  } ppu_mode_t;

  // Host visible registers used by the background layer
  typedef struct packed {
    byte_t lcdc;
    byte_t scx;
    byte_t scy;
  } ppu_regs_t;

  // Line timer state seen by fetcher and FIFO
  typedef struct packed {
    ppu_mode_t   mode;
    byte_t       ly;
    logic [8:0]  dot;
  } ppu_timing_t;

  // Four step tile fetch
  typedef enum logic [1:0] {
    FETCH_TILE,
    FETCH_LOW,
    FETCH_HIGH,
    FETCH_PUSH
  } fetch_state_t;

  // One tile row, leftmost pixel at index 0
  typedef gb_color_t [7:0] pixel_row_t;

  // Memory map
  localparam cpu_addr_t VRAM_BASE  = 16'h8000;
  localparam cpu_addr_t TILEMAP_0  = 16'h9800;
  localparam cpu_addr_t TILEMAP_1  = 16'h9C00;
  localparam cpu_addr_t TILEDATA_U = 16'h8000;
  localparam cpu_addr_t TILEDATA_S = 16'h9000;

endpackage

// ==== logic/ppu_vram.sv ====
module ppu_vram (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 we,
  input  ppu_pkg::cpu_addr_t   waddr,
  input  ppu_pkg::byte_t       wdata,
  input  ppu_pkg::vram_addr_t  rd_addr,
  output ppu_pkg::byte_t       rd_data
);

  // Size of the 0x8000-0x9FFF window
  localparam int VRAM_BYTES = 8192;

  ppu_pkg::byte_t mem [VRAM_BYTES];

  // Host address falls inside VRAM
  logic in_window;
  ppu_pkg::cpu_addr_t woffset;

  assign woffset   = waddr - ppu_pkg::VRAM_BASE;
  assign in_window = (waddr >= ppu_pkg::VRAM_BASE) &&
                     (waddr < ppu_pkg::VRAM_BASE + ppu_pkg::cpu_addr_t'(VRAM_BYTES));

  // Host write port, out of window writes are dropped
  always_ff @(posedge clk) begin
    if (we && in_window) begin
      mem[ppu_pkg::vram_addr_t'(woffset)] <= wdata;
    end
  end

  // Fetcher read port
  // Data shows up one cycle after the address
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== logic/ppu_line_timer.sv ====
module ppu_line_timer #(
  parameter int LINE_DOTS     = 456,
  parameter int FRAME_LINES   = 154,
  parameter int VISIBLE_LINES = 144,
  parameter int OAM_DOTS      = 80
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 line_done,
  output ppu_pkg::ppu_timing_t timing,
  output logic                 vblank
);

  // Count limits in the timing field widths
  localparam logic [8:0]     LAST_DOT  = 9'(LINE_DOTS - 1);
  localparam logic [8:0]     OAM_LAST  = 9'(OAM_DOTS - 1);
  localparam ppu_pkg::byte_t LAST_LINE = ppu_pkg::byte_t'(FRAME_LINES - 1);
  localparam ppu_pkg::byte_t VIS_LINES = ppu_pkg::byte_t'(VISIBLE_LINES);

  ppu_pkg::ppu_mode_t mode;
  ppu_pkg::byte_t     ly;
  logic [8:0]         dot;

  // Line that follows the current one, wrapping at frame end
  ppu_pkg::byte_t next_ly;
  logic           line_end;

  assign line_end = (dot == LAST_DOT);
  assign next_ly  = (ly == LAST_LINE) ? '0 : ly + 8'd1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode <= ppu_pkg::MODE_OAM;
      ly   <= '0;
      dot  <= '0;
    end else if (line_end) begin
      // New line, visible lines start with the OAM scan
      dot <= '0;
      ly  <= next_ly;
      if (next_ly >= VIS_LINES) begin
        mode <= ppu_pkg::MODE_VBLANK;
      end else begin
        mode <= ppu_pkg::MODE_OAM;
      end
    end else begin
      dot <= dot + 9'd1;
      unique case (mode)
        ppu_pkg::MODE_OAM: begin
          // Fixed length OAM scan
          if (dot == OAM_LAST) begin
            mode <= ppu_pkg::MODE_DRAW;
          end
        end
        ppu_pkg::MODE_DRAW: begin
          // Drawing ends when the FIFO sends the last pixel
          if (line_done) begin
            mode <= ppu_pkg::MODE_HBLANK;
          end
        end
        default: begin
          // HBLANK and VBLANK hold until line end
          mode <= mode;
        end
      endcase
    end
  end

  assign timing.mode = mode;
  assign timing.ly   = ly;
  assign timing.dot  = dot;

  assign vblank = (mode == ppu_pkg::MODE_VBLANK);

endmodule

// ==== logic/ppu_bg_fetcher.sv ====
module ppu_bg_fetcher #(
  parameter int LINE_TILES = 20
) (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_timing_t timing,
  input  ppu_pkg::ppu_regs_t   regs,
  input  ppu_pkg::byte_t       rd_data,
  input  logic                 empty,
  output ppu_pkg::vram_addr_t  rd_addr,
  output logic                 push,
  output ppu_pkg::pixel_row_t  row
);

  // Tile counter wide enough to hold LINE_TILES
  localparam int CW = $clog2(LINE_TILES + 1);
  localparam logic [CW-1:0] TILES_MAX = CW'(LINE_TILES);

  ppu_pkg::fetch_state_t state;

  // Phase 0 drives the address, phase 1 takes the data
  logic phase;

  // Tilemap column, wraps at 32 on its own
  logic [4:0] column;

  // Tiles pushed so far on this line
  logic [CW-1:0] tiles_done;

  // Fetched tile index and the two plane bytes
  ppu_pkg::byte_t tile_index;
  ppu_pkg::byte_t tile_low;
  ppu_pkg::byte_t tile_high;

  logic in_draw;
  logic fetching;
  logic do_push;

  assign in_draw  = (timing.mode == ppu_pkg::MODE_DRAW);
  assign fetching = in_draw && (tiles_done != TILES_MAX);
  assign do_push  = fetching && (state == ppu_pkg::FETCH_PUSH) && empty;

  // Background row in the 256x256 map, (SCY + LY) mod 256
  ppu_pkg::byte_t map_y;
  assign map_y = regs.scy + timing.ly;

  // Tilemap entry address
  ppu_pkg::cpu_addr_t map_base;
  ppu_pkg::cpu_addr_t map_addr;
  assign map_base = regs.lcdc[3] ? ppu_pkg::TILEMAP_1 : ppu_pkg::TILEMAP_0;
  assign map_addr = map_base + {6'b0, map_y[7:3], 5'b0} + {11'b0, column};

  // Tile data row address
  ppu_pkg::cpu_addr_t data_base;
  ppu_pkg::cpu_addr_t data_addr;
  always_comb begin
    if (regs.lcdc[4]) begin
      // Unsigned index from 0x8000
      data_base = ppu_pkg::TILEDATA_U + {4'b0, tile_index, 4'b0};
    end else begin
      // Signed index around 0x9000
      data_base = ppu_pkg::TILEDATA_S + {{4{tile_index[7]}}, tile_index, 4'b0};
    end
  end
  assign data_addr = data_base + {12'b0, map_y[2:0], 1'b0};

  // Read address held over both phases of a step
  ppu_pkg::cpu_addr_t cpu_rd_addr;
  always_comb begin
    unique case (state)
      ppu_pkg::FETCH_TILE: cpu_rd_addr = map_addr;
      ppu_pkg::FETCH_HIGH: cpu_rd_addr = data_addr + 16'd1;
      default:             cpu_rd_addr = data_addr;
    endcase
  end
  assign rd_addr = ppu_pkg::vram_addr_t'(cpu_rd_addr - ppu_pkg::VRAM_BASE);

  // Step sequencing
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= ppu_pkg::FETCH_TILE;
      phase      <= 1'b0;
      column     <= '0;
      tiles_done <= '0;
      push       <= 1'b0;
    end else begin
      push <= 1'b0;
      if (!in_draw) begin
        // Outside mode 3 park at the first tile of the next line
        state      <= ppu_pkg::FETCH_TILE;
        phase      <= 1'b0;
        column     <= regs.scx[7:3];
        tiles_done <= '0;
      end else if (fetching) begin
        unique case (state)
          ppu_pkg::FETCH_PUSH: begin
            // Wait here until the FIFO has drained
            if (empty) begin
              push       <= 1'b1;
              column     <= column + 5'd1;
              tiles_done <= tiles_done + 1'b1;
              state      <= ppu_pkg::FETCH_TILE;
            end
          end
          ppu_pkg::FETCH_TILE: begin
            phase <= ~phase;
            if (phase) state <= ppu_pkg::FETCH_LOW;
          end
          ppu_pkg::FETCH_LOW: begin
            phase <= ~phase;
            if (phase) state <= ppu_pkg::FETCH_HIGH;
          end
          default: begin
            phase <= ~phase;
            if (phase) state <= ppu_pkg::FETCH_PUSH;
          end
        endcase
      end
    end
  end

  // Data capture and row assembly
  always_ff @(posedge clk) begin
    if (fetching && phase) begin
      unique case (state)
        ppu_pkg::FETCH_TILE: tile_index <= rd_data;
        ppu_pkg::FETCH_LOW:  tile_low   <= rd_data;
        ppu_pkg::FETCH_HIGH: tile_high  <= rd_data;
        default:             tile_index <= tile_index;
      endcase
    end
    if (do_push) begin
      // Bit 7 is the leftmost pixel
      for (int i = 0; i < 8; i++) begin
        row[i] <= {tile_high[7-i], tile_low[7-i]};
      end
    end
  end

endmodule

// ==== logic/ppu_bg_fifo.sv ====
module ppu_bg_fifo #(
  parameter int LINE_TILES = 20
) (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_timing_t timing,
  input  logic                 push,
  input  ppu_pkg::pixel_row_t  row,
  output logic                 empty,
  output logic                 line_done,
  output logic                 pix_valid,
  output ppu_pkg::gb_color_t   pix_color,
  output ppu_pkg::byte_t       pix_x,
  output ppu_pkg::byte_t       pix_y
);

  // X of the last pixel on a line
  localparam ppu_pkg::byte_t LAST_X = ppu_pkg::byte_t'(LINE_TILES * 8 - 1);

  ppu_pkg::pixel_row_t pix_buf;
  logic [3:0]          count;
  ppu_pkg::byte_t      x_cnt;

  logic in_draw;
  logic emit;

  assign in_draw = (timing.mode == ppu_pkg::MODE_DRAW);
  assign empty   = (count == 4'd0);

  // A push sends its first pixel straight out
  assign emit = in_draw && (push || !empty);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count     <= '0;
      x_cnt     <= '0;
      pix_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      pix_valid <= emit;
      line_done <= emit && (x_cnt == LAST_X);
      if (timing.mode == ppu_pkg::MODE_OAM) begin
        // Line start
        count <= '0;
        x_cnt <= '0;
      end else if (emit) begin
        count <= push ? 4'd7 : count - 4'd1;
        x_cnt <= x_cnt + 8'd1;
      end
    end
  end

  // Pixel path, index 0 always holds the next pixel
  always_ff @(posedge clk) begin
    if (emit) begin
      if (push) begin
        pix_color <= row[0];
        pix_buf   <= ppu_pkg::pixel_row_t'(row >> 2);
      end else begin
        pix_color <= pix_buf[0];
        pix_buf   <= ppu_pkg::pixel_row_t'(pix_buf >> 2);
      end
      pix_x <= x_cnt;
      pix_y <= timing.ly;
    end
  end

endmodule

// ==== logic/ppu_bg_top.sv ====
module ppu_bg_top #(
  parameter int LINE_TILES    = 20,
  parameter int VISIBLE_LINES = 144,
  parameter int LINE_DOTS     = 456,
  parameter int FRAME_LINES   = 154,
  parameter int OAM_DOTS      = 80
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                vram_we,
  input  ppu_pkg::cpu_addr_t  vram_waddr,
  input  ppu_pkg::byte_t      vram_wdata,
  input  ppu_pkg::ppu_regs_t  regs,
  output logic                vblank,
  output logic                pix_valid,
  output ppu_pkg::gb_color_t  pix_color,
  output ppu_pkg::byte_t      pix_x,
  output ppu_pkg::byte_t      pix_y
);

  ppu_pkg::ppu_timing_t timing;
  ppu_pkg::vram_addr_t  rd_addr;
  ppu_pkg::byte_t       rd_data;
  ppu_pkg::pixel_row_t  row;
  logic                 push;
  logic                 empty;
  logic                 line_done;

  // Video memory shared by host and fetcher
  ppu_vram ppu_vram_i (
    .clk     (clk),
    .reset   (reset),
    .we      (vram_we),
    .waddr   (vram_waddr),
    .wdata   (vram_wdata),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  ppu_line_timer #(
    .LINE_DOTS     (LINE_DOTS),
    .FRAME_LINES   (FRAME_LINES),
    .VISIBLE_LINES (VISIBLE_LINES),
    .OAM_DOTS      (OAM_DOTS)
  ) ppu_line_timer_i (
    .clk       (clk),
    .reset     (reset),
    .line_done (line_done),
    .timing    (timing),
    .vblank    (vblank)
  );

  ppu_bg_fetcher #(.LINE_TILES(LINE_TILES)) ppu_bg_fetcher_i (
    .clk     (clk),
    .reset   (reset),
    .timing  (timing),
    .regs    (regs),
    .rd_data (rd_data),
    .empty   (empty),
    .rd_addr (rd_addr),
    .push    (push),
    .row     (row)
  );

  // Pixel output stage
  ppu_bg_fifo #(.LINE_TILES(LINE_TILES)) ppu_bg_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .timing    (timing),
    .push      (push),
    .row       (row),
    .empty     (empty),
    .line_done (line_done),
    .pix_valid (pix_valid),
    .pix_color (pix_color),
    .pix_x     (pix_x),
    .pix_y     (pix_y)
  );

endmodule

// ==== verif/ppu_bg_chk.sv ====
module ppu_bg_chk (
  input logic               clk,
  input logic               reset,
  input ppu_pkg::ppu_mode_t mode,
  input logic               push,
  input logic               empty,
  input logic               pix_valid
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Fetcher only loads a drained FIFO
  push_into_empty: assert property (@(posedge clk) disable iff (reset) push |-> empty)
    else begin
      $error("push while the FIFO still holds pixels");
      fail_count++;
    end

  // Pixels only come out while drawing
  pixel_in_draw: assert property (
    @(posedge clk) disable iff (reset) pix_valid |-> (mode == ppu_pkg::MODE_DRAW))
    else begin
      $error("pixel output outside mode 3");
      fail_count++;
    end

  // OAM scan hands over to drawing
  oam_then_draw: assert property (
    @(posedge clk) disable iff (reset)
    (mode == ppu_pkg::MODE_OAM) |=> (mode == ppu_pkg::MODE_OAM || mode == ppu_pkg::MODE_DRAW))
    else begin
      $error("mode 2 was not followed by mode 3");
      fail_count++;
    end

  // Quiet outputs and OAM scan when reset is released
  reset_state: assert property (
    @(posedge clk) $fell(reset) |-> (!pix_valid && !push && mode == ppu_pkg::MODE_OAM))
    else begin
      $error("outputs or mode not at their reset values");
      fail_count++;
    end

endmodule

// ==== verif/ppu_bg_tb.sv ====
module ppu_bg_tb;

  // Short frame of 4 tiles by 6 lines
  localparam int LINE_TILES    = 4;
  localparam int VISIBLE_LINES = 6;
  localparam int LINE_DOTS     = 160;
  localparam int FRAME_LINES   = 8;
  localparam int OAM_DOTS      = 20;
  localparam int CLK_PERIOD    = 20;
  localparam int DRIVE_DELAY   = 2;
  localparam int NUM_FRAMES    = 12;
  localparam int LINE_PIX      = LINE_TILES * 8;

  // One frame per load plus a drain frame and some slack
  localparam int FRAME_TIME = FRAME_LINES * LINE_DOTS * CLK_PERIOD;
  localparam int TIMEOUT    = (NUM_FRAMES + 1) * FRAME_TIME + 4 * LINE_DOTS * CLK_PERIOD;

  logic               clk;
  logic               reset;
  logic               vram_we;
  ppu_pkg::cpu_addr_t vram_waddr;
  ppu_pkg::byte_t     vram_wdata;
  ppu_pkg::ppu_regs_t regs;
  logic               vblank;
  logic               pix_valid;
  ppu_pkg::gb_color_t pix_color;
  ppu_pkg::byte_t     pix_x;
  ppu_pkg::byte_t     pix_y;

  integer seed;

  // Host side copy of VRAM indexed by the offset from 0x8000
  ppu_pkg::byte_t mirror [8192];

  // Monitor state
  logic model_ready = 1'b0;
  logic vblank_prev = 1'b0;
  int   error_count = 0;
  int   pix_checked = 0;
  int   dots_run    = 0;
  int   x_next      = 0;
  int   exp_line    = 0;

  ppu_bg_top #(
    .LINE_TILES    (LINE_TILES),
    .VISIBLE_LINES (VISIBLE_LINES),
    .LINE_DOTS     (LINE_DOTS),
    .FRAME_LINES   (FRAME_LINES),
    .OAM_DOTS      (OAM_DOTS)
  ) ppu_bg_top_i (
    .clk        (clk),
    .reset      (reset),
    .vram_we    (vram_we),
    .vram_waddr (vram_waddr),
    .vram_wdata (vram_wdata),
    .regs       (regs),
    .vblank     (vblank),
    .pix_valid  (pix_valid),
    .pix_color  (pix_color),
    .pix_x      (pix_x),
    .pix_y      (pix_y)
  );

  bind ppu_bg_top ppu_bg_chk ppu_bg_chk_i (
    .clk       (clk),
    .reset     (reset),
    .mode      (timing.mode),
    .push      (push),
    .empty     (empty),
    .pix_valid (pix_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h at time %0t", name, got, exp, $time);
      abort_run();
    end
  endtask

  function automatic ppu_pkg::byte_t mirror_read(input ppu_pkg::cpu_addr_t addr);
    return mirror[int'(addr) - int'(ppu_pkg::VRAM_BASE)];
  endfunction

  // Tilemap entry for a tile slot of a screen line
  function automatic ppu_pkg::cpu_addr_t map_address(input int line, input int tile);
    int map_y;
    int col;
    int base;
    map_y = (int'(regs.scy) + line) % 256;
    // Column wraps inside the 32 wide map
    col   = (int'(regs.scx) / 8 + tile) % 32;
    base  = regs.lcdc[3] ? int'(ppu_pkg::TILEMAP_1) : int'(ppu_pkg::TILEMAP_0);
    return ppu_pkg::cpu_addr_t'(base + (map_y / 8) * 32 + col);
  endfunction

  // Low plane address of the tile row on a screen line
  function automatic ppu_pkg::cpu_addr_t data_address(input ppu_pkg::byte_t index,
                                                      input int line);
    int map_y;
    int tile_num;
    int base;
    map_y = (int'(regs.scy) + line) % 256;
    if (regs.lcdc[4]) begin
      base = int'(ppu_pkg::TILEDATA_U) + int'(index) * 16;
    end else begin
      // Index taken as two's complement around 0x9000
      tile_num = (index >= 128) ? int'(index) - 256 : int'(index);
      base     = int'(ppu_pkg::TILEDATA_S) + tile_num * 16;
    end
    return ppu_pkg::cpu_addr_t'(base + (map_y % 8) * 2);
  endfunction

  function automatic ppu_pkg::gb_color_t expected_color(input int x, input int line);
    ppu_pkg::cpu_addr_t addr;
    ppu_pkg::byte_t     low;
    ppu_pkg::byte_t     high;
    int                 bit_pos;
    addr    = data_address(mirror_read(map_address(line, x / 8)), line);
    low     = mirror_read(addr);
    high    = mirror_read(addr + 16'd1);
    // Bit 7 is the leftmost pixel of a tile
    bit_pos = 7 - (x % 8);
    return {high[bit_pos], low[bit_pos]};
  endfunction

  // One write strobe per clock
  // Mirror follows the VRAM window only
  task automatic host_write(input ppu_pkg::cpu_addr_t addr, input ppu_pkg::byte_t data);
    @(posedge clk);
    #(DRIVE_DELAY);
    vram_we    = 1'b1;
    vram_waddr = addr;
    vram_wdata = data;
    if (addr >= ppu_pkg::VRAM_BASE && addr <= 16'h9FFF) begin
      mirror[int'(addr) - int'(ppu_pkg::VRAM_BASE)] = data;
    end
  endtask

  // Loads registers and VRAM for the next frame during vblank
  task automatic load_frame(input int frame);
    logic [31:0]        rnd;
    ppu_pkg::cpu_addr_t addr;
    int                 line;
    int                 tile;
    @(posedge clk);
    #(DRIVE_DELAY);
    rnd       = $random(seed);
    regs.lcdc = rnd[7:0];
    regs.scx  = rnd[15:8];
    regs.scy  = rnd[23:16];
    // Sweep both data addressing modes and both tilemaps
    regs.lcdc[4] = frame[0];
    regs.lcdc[3] = frame[1];
    // Every fourth frame crosses map column 31 and row 255
    if (frame % 4 == 3) begin
      regs.scx = 8'hF0 | {4'h0, rnd[27:24]};
      regs.scy = 8'hFC | {6'h0, rnd[29:28]};
    end
    // Random bytes anywhere in VRAM
    repeat (24) begin
      rnd = $random(seed);
      host_write(ppu_pkg::VRAM_BASE + {3'b0, rnd[12:0]}, rnd[23:16]);
    end
    // Tilemap entries the frame will fetch
    for (line = 0; line < VISIBLE_LINES; line++) begin
      for (tile = 0; tile < LINE_TILES; tile++) begin
        rnd = $random(seed);
        host_write(map_address(line, tile), rnd[7:0]);
      end
    end
    // Both planes of every fetched tile row
    for (line = 0; line < VISIBLE_LINES; line++) begin
      for (tile = 0; tile < LINE_TILES; tile++) begin
        addr = data_address(mirror_read(map_address(line, tile)), line);
        rnd  = $random(seed);
        host_write(addr, rnd[7:0]);
        host_write(addr + 16'd1, rnd[15:8]);
      end
    end
    // Aliases 8 KiB below or above fetched bytes that the VRAM must drop
    repeat (16) begin
      rnd  = $random(seed);
      line = int'(rnd[7:0]) % VISIBLE_LINES;
      tile = int'(rnd[15:8]) % LINE_TILES;
      if (rnd[16]) begin
        addr = map_address(line, tile);
      end else begin
        addr = data_address(mirror_read(map_address(line, tile)), line) + {15'b0, rnd[17]};
      end
      addr = rnd[18] ? addr + 16'h2000 : addr - 16'h2000;
      host_write(addr, rnd[31:24]);
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    vram_we = 1'b0;
    if (!vblank) begin
      $display("ERROR: host writes for frame %0d ran past the end of vblank", frame);
      abort_run();
    end
    model_ready = 1'b1;
  endtask

  // Pixel monitor sampling at the falling edge where outputs are stable
  always @(negedge clk) begin
    // Bound checker assertions end the run at their first failure
    if (ppu_bg_top_i.ppu_bg_chk_i.fail_count != 0) begin
      $display("ERROR: an assertion in the bound checker failed");
      abort_run();
    end
    if (reset === 1'b0) begin
      // Vblank covers the lines past the visible ones, one dot per clock since reset
      check_value("vblank", vblank, ((dots_run / LINE_DOTS) % FRAME_LINES) >= VISIBLE_LINES);
      dots_run++;
      if (vblank && !vblank_prev) begin
        // Last visible line must be complete at frame end
        check_value("line pixel count", x_next, LINE_PIX);
        check_value("last visible line", exp_line, VISIBLE_LINES - 1);
        x_next   = 0;
        exp_line = 0;
      end
      vblank_prev = vblank;
      if (pix_valid) begin
        if (vblank) begin
          $display("ERROR: pixel output during vblank at x %0d y %0d", pix_x, pix_y);
          abort_run();
        end
        if (x_next == LINE_PIX) begin
          exp_line++;
          x_next = 0;
        end
        check_value("pix_y", pix_y, exp_line);
        check_value("pix_x", pix_x, x_next);
        // Frame 0 draws from VRAM that was never written
        if (model_ready) begin
          check_value("pix_color", pix_color, expected_color(x_next, exp_line));
          pix_checked++;
        end
        x_next++;
      end
    end
  end

  initial begin
    #(TIMEOUT);
    $display("ERROR: watchdog timed out before all frames were drawn");
    abort_run();
  end

  initial begin
    seed       = 32'h1803_cae3;
    reset      = 1'b1;
    vram_we    = 1'b0;
    vram_waddr = '0;
    vram_wdata = '0;
    regs       = '0;
    repeat (5) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;
    for (int frame = 0; frame < NUM_FRAMES; frame++) begin
      @(posedge vblank);
      load_frame(frame);
    end
    // Last loaded frame ends at the next vblank
    @(posedge vblank);
    @(negedge clk);
    @(negedge clk);
    check_value("checked pixel count", pix_checked, NUM_FRAMES * VISIBLE_LINES * LINE_PIX);
    if (error_count == 0 && ppu_bg_top_i.ppu_bg_chk_i.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/ppu_pkg.sv
logic/ppu_vram.sv
logic/ppu_line_timer.sv
logic/ppu_bg_fetcher.sv
logic/ppu_bg_fifo.sv
logic/ppu_bg_top.sv
verif/ppu_bg_chk.sv
verif/ppu_bg_tb.sv
